// File: hl2_ctrl.f
+incdir+src
src/hl2_ctrl_pkg.sv
src/cmd_ctrl.sv
src/disc_reply_gen.sv
src/resp_builder.sv
src/hl2_ctrl_core.sv
verification/hl2_ctrl_tb.sv

// File: src/cmd_ctrl.sv
`default_nettype none

`include "hl2_ctrl_config.svh"

module cmd_ctrl
  import hl2_ctrl_pkg::*;
(
  input  logic        clk_ctrl,
  input  logic        reset_i,

  // host command
  input  logic        cmd_strobe_i,
  input  cmd_addr_t   cmd_addr_i,
  input  cmd_data_t   cmd_data_i,
  input  logic        cmd_resp_i,

  // discovery
  input  logic        disc_rqst_i,
  input  logic        disc_last_i,

  output logic        run_o,
  output alt_mac_t    alt_mac_o,
  output cfg_byte_t   cfg_byte_o,
  output logic        disc_start_o,
  output logic        resp_rqst_o,
  output cmd_addr_t   resp_addr_o
);

  ctrl_state_t state_q;
  ctrl_state_t state_d;

  logic wr_run;
  logic wr_eeprom;
  logic disc_accept;

  //////////////////////////////////////////////////////////////////////////
  // command decode

  assign wr_run    = cmd_strobe_i && (cmd_addr_i == `HL2_ADDR_RUN);
  assign wr_eeprom = cmd_strobe_i && (cmd_addr_i == `HL2_ADDR_EEPROM);

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      run_o <= 1'b0;
    end else if (wr_run) begin
      run_o <= cmd_data_i[0];
    end
  end

  // alternate mac and config byte arrive in one word
  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      alt_mac_o  <= '0;
      cfg_byte_o <= '0;
    end else if (wr_eeprom) begin
      alt_mac_o  <= cmd_data_i[15:0];
      cfg_byte_o <= cmd_data_i[23:16];
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // response request

  // one cycle behind the command, so the response sees the written values
  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      resp_rqst_o <= 1'b0;
    end else begin
      resp_rqst_o <= cmd_strobe_i && cmd_resp_i;
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (cmd_strobe_i) begin
      resp_addr_o <= cmd_addr_i;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // discovery fsm

  // only while idle and not streaming radio data
  assign disc_accept = disc_rqst_i && (state_q == CTRL_IDLE) && !run_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_IDLE: begin
        if (disc_accept) begin
          state_d = CTRL_REPLY;
        end
      end
      CTRL_REPLY: begin
        // serializer flags its final byte
        if (disc_last_i) begin
          state_d = CTRL_IDLE;
        end
      end
      default: begin
        state_d = CTRL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      state_q      <= CTRL_IDLE;
      disc_start_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      disc_start_o <= disc_accept;
    end
  end

endmodule

`default_nettype wire

// File: src/disc_reply_gen.sv
`default_nettype none

`include "hl2_ctrl_config.svh"

module disc_reply_gen
  import hl2_ctrl_pkg::*;
(
  input  logic        clk_ctrl,
  input  logic        reset_i,

  input  logic        start_i,
  input  logic        alt_mac_pin_i,
  input  alt_mac_t    alt_mac_i,
  input  cfg_byte_t   cfg_byte_i,

  output reply_byte_t data_o,
  output logic        valid_o,
  output logic        last_o
);

  localparam int unsigned REPLY_W = `HL2_DISC_LEN * 8;
  localparam int unsigned CNT_W   = $clog2(`HL2_DISC_LEN);
  localparam mac_addr_t   BASE_MAC = `HL2_BASE_MAC;

  mac_addr_t          local_mac;
  logic               use_alt_mac;
  logic [REPLY_W-1:0] reply_q;
  logic [CNT_W-1:0]   byte_cnt_q;
  logic               valid_q;

  //////////////////////////////////////////////////////////////////////////
  // local mac selection

  assign use_alt_mac = cfg_byte_i[`HL2_CFG_ALT_MAC_BIT];

  // strap pin lands inverted on bit 1 of the base mac
  assign local_mac = use_alt_mac ? {BASE_MAC[47:16], alt_mac_i}
                                 : {BASE_MAC[47:2], ~alt_mac_pin_i, BASE_MAC[0]};

  //////////////////////////////////////////////////////////////////////////
  // reply serializer

  // loaded once at start, then shifted out msb byte first
  always_ff @(posedge clk_ctrl) begin
    if (start_i) begin
      reply_q <= {local_mac, `HL2_VERSION_MAJOR, `HL2_VERSION_MINOR,
                  `HL2_BOARD_ID, cfg_byte_i};
    end else if (valid_q) begin
      reply_q <= {reply_q[REPLY_W-9:0], 8'h00};
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      valid_q    <= 1'b0;
      byte_cnt_q <= '0;
    end else if (start_i) begin
      valid_q    <= 1'b1;
      byte_cnt_q <= '0;
    end else if (valid_q) begin
      if (last_o) begin
        valid_q    <= 1'b0;
        byte_cnt_q <= '0;
      end else begin
        byte_cnt_q <= byte_cnt_q + 1'b1;
      end
    end
  end

  assign data_o  = reply_q[REPLY_W-1 -: 8];
  assign valid_o = valid_q;

  // final byte of the fixed length reply
  assign last_o  = valid_q && (byte_cnt_q == CNT_W'(`HL2_DISC_LEN - 1));

endmodule

`default_nettype wire

// File: src/hl2_ctrl_config.svh
`ifndef HL2_CTRL_CONFIG_SVH
`define HL2_CTRL_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// command addresses

// data bit 0 is run
`define HL2_ADDR_RUN          6'h00
// data 15..0 alternate mac low half, 23..16 configuration byte
`define HL2_ADDR_EEPROM       6'h3b

////////////////////////////////////////////////////////////////////////////
// board identity

`define HL2_VERSION_MAJOR     8'd69
`define HL2_VERSION_MINOR     8'd3
`define HL2_BOARD_ID          8'd5

// base mac, bit 1 is replaced by the strap pin
`define HL2_BASE_MAC          48'h001cc0a213dd

// config byte bit selecting the alternate mac
`define HL2_CFG_ALT_MAC_BIT   6

////////////////////////////////////////////////////////////////////////////
// discovery reply

// six mac bytes, version major/minor, board id, config byte
`define HL2_DISC_LEN          10

`endif

// File: src/hl2_ctrl_core.sv
`default_nettype none

module hl2_ctrl_core
  import hl2_ctrl_pkg::*;
(
  input  logic        clk_ctrl,
  input  logic        reset_i,

  // host command
  input  logic        cmd_strobe_i,
  input  cmd_addr_t   cmd_addr_i,
  input  cmd_data_t   cmd_data_i,
  input  logic        cmd_resp_i,

  input  logic        disc_rqst_i,
  input  logic        alt_mac_pin_i,
  input  logic        rxclip_i,
  input  logic        rxgoodlvl_i,

  output logic        run_o,

  // discovery reply stream
  output reply_byte_t disc_data_o,
  output logic        disc_valid_o,
  output logic        disc_last_o,

  // status response
  output resp_word_t  resp_data_o,
  output logic        resp_valid_o
);

  alt_mac_t  alt_mac;
  cfg_byte_t cfg_byte;
  logic      disc_start;
  logic      resp_rqst;
  cmd_addr_t resp_addr;

  ////////////////////////////////////////////////////////////////////////////
  // control

  cmd_ctrl cmd_ctrl_i (
    .clk_ctrl     (clk_ctrl),
    .reset_i      (reset_i),
    .cmd_strobe_i (cmd_strobe_i),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_data_i   (cmd_data_i),
    .cmd_resp_i   (cmd_resp_i),
    .disc_rqst_i  (disc_rqst_i),
    .disc_last_i  (disc_last_o),
    .run_o        (run_o),
    .alt_mac_o    (alt_mac),
    .cfg_byte_o   (cfg_byte),
    .disc_start_o (disc_start),
    .resp_rqst_o  (resp_rqst),
    .resp_addr_o  (resp_addr)
  );

  ////////////////////////////////////////////////////////////////////////////
  // datapath

  disc_reply_gen disc_reply_gen_i (
    .clk_ctrl      (clk_ctrl),
    .reset_i       (reset_i),
    .start_i       (disc_start),
    .alt_mac_pin_i (alt_mac_pin_i),
    .alt_mac_i     (alt_mac),
    .cfg_byte_i    (cfg_byte),
    .data_o        (disc_data_o),
    .valid_o       (disc_valid_o),
    .last_o        (disc_last_o)
  );

  resp_builder resp_builder_i (
    .clk_ctrl     (clk_ctrl),
    .reset_i      (reset_i),
    .rqst_i       (resp_rqst),
    .addr_i       (resp_addr),
    .run_i        (run_o),
    .cfg_byte_i   (cfg_byte),
    .rxclip_i     (rxclip_i),
    .rxgoodlvl_i  (rxgoodlvl_i),
    .resp_o       (resp_data_o),
    .resp_valid_o (resp_valid_o)
  );

endmodule

`default_nettype wire

// File: src/hl2_ctrl_pkg.sv
`default_nettype none

package hl2_ctrl_pkg;

  // host command interface
  typedef logic [5:0]  cmd_addr_t;
  typedef logic [31:0] cmd_data_t;

  // ethernet mac and the alternate low half
  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] alt_mac_t;

  // eeprom configuration byte
  typedef logic [7:0]  cfg_byte_t;

  // one byte of the discovery reply stream
  typedef logic [7:0]  reply_byte_t;

  // status response
  // 39..34 addr, 33 run, 32 zero, 31..24 ver major, 23..16 ver minor,
  // 15..8 config, 7..2 zero, 1 clip, 0 good level
  typedef logic [39:0] resp_word_t;

  // discovery sequencing
  typedef enum logic {
    CTRL_IDLE,
    CTRL_REPLY
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: src/resp_builder.sv
`default_nettype none

`include "hl2_ctrl_config.svh"

module resp_builder
  import hl2_ctrl_pkg::*;
(
  input  logic        clk_ctrl,
  input  logic        reset_i,

  input  logic        rqst_i,
  input  cmd_addr_t   addr_i,
  input  logic        run_i,
  input  cfg_byte_t   cfg_byte_i,

  // receive status, levels
  input  logic        rxclip_i,
  input  logic        rxgoodlvl_i,

  output resp_word_t  resp_o,
  output logic        resp_valid_o
);

  logic clip_q;
  logic good_q;
  logic clip_now;
  logic good_now;

  //////////////////////////////////////////////////////////////////////////
  // sticky receive flags

  // include this cycle's input in the word being built
  assign clip_now = clip_q | rxclip_i;
  assign good_now = good_q | rxgoodlvl_i;

  // cleared when reported, set again by any later high input
  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      clip_q <= 1'b0;
      good_q <= 1'b0;
    end else if (rqst_i) begin
      clip_q <= 1'b0;
      good_q <= 1'b0;
    end else begin
      clip_q <= clip_now;
      good_q <= good_now;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // response word

  always_ff @(posedge clk_ctrl) begin
    if (rqst_i) begin
      resp_o <= {addr_i, run_i, 1'b0,
                 `HL2_VERSION_MAJOR, `HL2_VERSION_MINOR,
                 cfg_byte_i, 6'b000000, clip_now, good_now};
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= rqst_i;
    end
  end

endmodule

`default_nettype wire

// File: verification/hl2_ctrl_tb.sv
`default_nettype none

`include "hl2_ctrl_config.svh"

module hl2_ctrl_tb
  import hl2_ctrl_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int        CLK_PERIOD   = 8;
  localparam int        RESET_CYCLES = 8;
  localparam int        DISC_CYCLES  = `HL2_DISC_LEN + 8;
  localparam int        TEST_CYCLES  = RESET_CYCLES + 5 * DISC_CYCLES + 40;
  localparam int        REPLY_W      = 8 * `HL2_DISC_LEN;
  localparam mac_addr_t BASE_MAC     = `HL2_BASE_MAC;
  // unmapped address whose writes change no register
  localparam cmd_addr_t SPARE_ADDR   = 6'h15;

  logic        clk_ctrl;
  logic        reset_i;
  logic        cmd_strobe_i;
  cmd_addr_t   cmd_addr_i;
  cmd_data_t   cmd_data_i;
  logic        cmd_resp_i;
  logic        disc_rqst_i;
  logic        alt_mac_pin_i;
  logic        rxclip_i;
  logic        rxgoodlvl_i;
  logic        run_o;
  reply_byte_t disc_data_o;
  logic        disc_valid_o;
  logic        disc_last_o;
  resp_word_t  resp_data_o;
  logic        resp_valid_o;

  integer      seed;
  int          err_cnt;
  // last eeprom word written by the host
  alt_mac_t    cur_alt;
  cfg_byte_t   cur_cfg;

  hl2_ctrl_core dut_i (
    .clk_ctrl      (clk_ctrl),
    .reset_i       (reset_i),
    .cmd_strobe_i  (cmd_strobe_i),
    .cmd_addr_i    (cmd_addr_i),
    .cmd_data_i    (cmd_data_i),
    .cmd_resp_i    (cmd_resp_i),
    .disc_rqst_i   (disc_rqst_i),
    .alt_mac_pin_i (alt_mac_pin_i),
    .rxclip_i      (rxclip_i),
    .rxgoodlvl_i   (rxgoodlvl_i),
    .run_o         (run_o),
    .disc_data_o   (disc_data_o),
    .disc_valid_o  (disc_valid_o),
    .disc_last_o   (disc_last_o),
    .resp_data_o   (resp_data_o),
    .resp_valid_o  (resp_valid_o)
  );

  always #(CLK_PERIOD / 2) clk_ctrl = ~clk_ctrl;

  initial begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d ns, the tests did not finish",
             2 * TEST_CYCLES * CLK_PERIOD);
    $display("RESULT: FAIL");
    $fatal(1, "watchdog timeout");
  end

  ////////////////////////////////////////////////////////////////////////////
  // expected values

  // base mac with the strap pin on bit 1 or with its low half replaced
  function automatic mac_addr_t expected_mac(input logic pin, input alt_mac_t alt,
                                             input cfg_byte_t cfg);
    mac_addr_t mac;
    mac = BASE_MAC;
    if (cfg[`HL2_CFG_ALT_MAC_BIT]) begin
      mac[15:0] = alt;
    end else begin
      mac[1] = ~pin;
    end
    return mac;
  endfunction

  // mac msb first, then version, board id, config
  function automatic logic [REPLY_W-1:0] expected_reply(input mac_addr_t mac,
                                                        input cfg_byte_t cfg);
    return {mac, `HL2_VERSION_MAJOR, `HL2_VERSION_MINOR, `HL2_BOARD_ID, cfg};
  endfunction

  function automatic resp_word_t expected_resp(input cmd_addr_t addr, input logic run,
                                               input cfg_byte_t cfg, input logic clip,
                                               input logic good);
    return {addr, run, 1'b0, `HL2_VERSION_MAJOR, `HL2_VERSION_MINOR,
            cfg, 6'b000000, clip, good};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // checks and drivers entered and left on a falling edge

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    if (exp !== act) begin
      err_cnt++;
      $display("Mismatch in %s: expected %0h, actual %0h", name, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic report_failure(input string what);
    err_cnt++;
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "protocol check failed");
  endtask

  task automatic send_cmd(input cmd_addr_t addr, input cmd_data_t data, input logic resp);
    cmd_strobe_i = 1'b1;
    cmd_addr_i   = addr;
    cmd_data_i   = data;
    cmd_resp_i   = resp;
    @(negedge clk_ctrl);
    cmd_strobe_i = 1'b0;
    cmd_resp_i   = 1'b0;
  endtask

  // called straight after send_cmd so valid is due one cycle later
  task automatic expect_resp(input string name, input resp_word_t exp);
    if (resp_valid_o) begin
      report_failure($sformatf("%s: resp_valid_o came one cycle early", name));
    end
    @(negedge clk_ctrl);
    if (!resp_valid_o) begin
      report_failure($sformatf("%s: resp_valid_o missing two cycles after command", name));
    end
    check_value(name, exp, resp_data_o);
    @(negedge clk_ctrl);
    if (resp_valid_o) begin
      report_failure($sformatf("%s: resp_valid_o stayed high past one cycle", name));
    end
  endtask

  // extra_at names the reply byte that gets a second request or is -1 for none
  task automatic collect_disc(input string name, input logic [REPLY_W-1:0] exp,
                              input int extra_at);
    int i;
    disc_rqst_i = 1'b1;
    @(negedge clk_ctrl);
    disc_rqst_i = 1'b0;
    if (disc_valid_o) begin
      report_failure($sformatf("%s: disc_valid_o came one cycle early", name));
    end
    for (i = 0; i < `HL2_DISC_LEN; i++) begin
      @(negedge clk_ctrl);
      disc_rqst_i = (i == extra_at);
      if (!disc_valid_o) begin
        report_failure($sformatf("%s: disc_valid_o missing on reply byte %0d", name, i));
      end
      check_value($sformatf("%s byte %0d", name, i), exp[REPLY_W-1-8*i -: 8], disc_data_o);
      if ((i == `HL2_DISC_LEN - 1) && !disc_last_o) begin
        report_failure($sformatf("%s: disc_last_o missing on the final byte", name));
      end
      if ((i != `HL2_DISC_LEN - 1) && disc_last_o) begin
        report_failure($sformatf("%s: disc_last_o high on byte %0d", name, i));
      end
    end
    repeat (4) begin
      @(negedge clk_ctrl);
      disc_rqst_i = 1'b0;
      if (disc_valid_o) begin
        report_failure($sformatf("%s: disc_valid_o still high after the reply", name));
      end
    end
  endtask

  task automatic expect_no_disc(input string name, input int cycles);
    disc_rqst_i = 1'b1;
    @(negedge clk_ctrl);
    disc_rqst_i = 1'b0;
    repeat (cycles) begin
      if (disc_valid_o) begin
        report_failure($sformatf("%s: disc_valid_o rose for a dropped request", name));
      end
      @(negedge clk_ctrl);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests

  task automatic test_after_reset();
    check_value("after_reset run_o", 64'd0, run_o);
    check_value("after_reset disc_valid_o", 64'd0, disc_valid_o);
    check_value("after_reset resp_valid_o", 64'd0, resp_valid_o);
    alt_mac_pin_i = 1'b0;
    collect_disc("after_reset pin0",
                 expected_reply(expected_mac(1'b0, '0, '0), 8'h00), -1);
    alt_mac_pin_i = 1'b1;
    collect_disc("after_reset pin1",
                 expected_reply(expected_mac(1'b1, '0, '0), 8'h00), -1);
  endtask

  task automatic test_resp_word();
    cmd_data_t data;
    data    = $random(seed);
    cur_alt = data[15:0];
    cur_cfg = data[23:16];
    send_cmd(`HL2_ADDR_EEPROM, data, 1'b1);
    expect_resp("resp_word", expected_resp(`HL2_ADDR_EEPROM, 1'b0, cur_cfg, 1'b0, 1'b0));
  endtask

  task automatic test_alt_mac();
    cmd_data_t data;
    data = $random(seed);
    data[16 + `HL2_CFG_ALT_MAC_BIT] = 1'b1;
    cur_alt = data[15:0];
    cur_cfg = data[23:16];
    send_cmd(`HL2_ADDR_EEPROM, data, 1'b0);
    @(negedge clk_ctrl);
    collect_disc("alt_mac", expected_reply({BASE_MAC[47:16], cur_alt}, cur_cfg), -1);
  endtask

  task automatic test_run_blocks_disc();
    send_cmd(`HL2_ADDR_RUN, 32'h0000_0001, 1'b1);
    check_value("run_blocks run_o set", 64'd1, run_o);
    expect_resp("run_blocks resp", expected_resp(`HL2_ADDR_RUN, 1'b1, cur_cfg, 1'b0, 1'b0));
    expect_no_disc("run_blocks", DISC_CYCLES);
    send_cmd(`HL2_ADDR_RUN, 32'h0000_0000, 1'b0);
    check_value("run_blocks run_o clear", 64'd0, run_o);
    // second request lands on byte 3 of the reply
    collect_disc("busy_drop",
                 expected_reply(expected_mac(alt_mac_pin_i, cur_alt, cur_cfg), cur_cfg), 3);
  endtask

  task automatic pulse_status(input string name, input logic clip, input logic good);
    rxclip_i    = clip;
    rxgoodlvl_i = good;
    @(negedge clk_ctrl);
    rxclip_i    = 1'b0;
    rxgoodlvl_i = 1'b0;
    @(negedge clk_ctrl);
    send_cmd(SPARE_ADDR, 32'hffff_ffff, 1'b1);
    expect_resp($sformatf("%s set", name),
                expected_resp(SPARE_ADDR, 1'b0, cur_cfg, clip, good));
    send_cmd(SPARE_ADDR, 32'hffff_ffff, 1'b1);
    expect_resp($sformatf("%s cleared", name),
                expected_resp(SPARE_ADDR, 1'b0, cur_cfg, 1'b0, 1'b0));
  endtask

  task automatic test_sticky_flags();
    pulse_status("sticky_clip", 1'b1, 1'b0);
    pulse_status("sticky_good", 1'b0, 1'b1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    seed          = 32'h7487d1d0;
    err_cnt       = 0;
    cur_alt       = '0;
    cur_cfg       = '0;
    clk_ctrl      = 1'b0;
    reset_i       = 1'b1;
    cmd_strobe_i  = 1'b0;
    cmd_addr_i    = '0;
    cmd_data_i    = '0;
    cmd_resp_i    = 1'b0;
    disc_rqst_i   = 1'b0;
    alt_mac_pin_i = 1'b0;
    rxclip_i      = 1'b0;
    rxgoodlvl_i   = 1'b0;

    repeat (RESET_CYCLES) @(posedge clk_ctrl);
    @(negedge clk_ctrl);
    reset_i = 1'b0;
    @(negedge clk_ctrl);

    test_after_reset();
    test_resp_word();
    test_alt_mac();
    test_run_blocks_disc();
    test_sticky_flags();

    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
